//--- all.f
accel_pkg.sv
accel_ctrl.sv
weight_dma.sv
weight_sram.sv
weight_bank.sv
fc_classifier.sv
nice_accel_top.sv
tb_itcm.sv
tb_nice_accel.sv

//--- run.sh
#!/bin/sh
# build and run the accelerator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_nice_accel -f all.f -o sim_nice_accel

out=$(./obj_dir/sim_nice_accel)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
  exit 0
else
  exit 1
fi

//--- tb_nice_accel.sv
`timescale 1ns/1ps

module tb_nice_accel;

  localparam int FEAT_NUM  = 12;
  localparam int NUM_WORDS = accel_pkg::NUM_BANK * FEAT_NUM;
  localparam int WATCHDOG_CYC = 2 * (NUM_WORDS + NUM_WORDS + 80) + 30 * 40 + 200;

  typedef accel_pkg::feat_t [FEAT_NUM-1:0] feat_vec_t;

  logic                    clk;
  logic                    rst_n;
  logic                    i_start;
  feat_vec_t               i_feat;
  logic                    i_feat_valid;
  accel_pkg::weight_word_t itcm_data;
  accel_pkg::itcm_addr_t   o_itcm_addr;
  logic                    o_data_ready;
  accel_pkg::class_idx_t   o_result;
  logic                    o_result_valid;
  logic                    wr_en;
  accel_pkg::itcm_addr_t   wr_addr;
  accel_pkg::weight_word_t wr_data;

  accel_pkg::weight_word_t w_mem [NUM_WORDS]; // copy of the loaded weights
  logic [31:0]             lfsr_q = 32'h8e70;
  int                      val_errs   = 0;
  int                      other_errs = 0;
  int                      pulse_cnt  = 0;
  int                      exp_pulses = 0;
  accel_pkg::class_idx_t   last_result;

  nice_accel_top #(.FEAT_NUM(FEAT_NUM)) i_nice_accel_top (
    .clk(clk), .rst_n(rst_n), .i_start(i_start), .i_feat(i_feat),
    .i_feat_valid(i_feat_valid), .i_itcm_data(itcm_data), .o_itcm_addr(o_itcm_addr),
    .o_data_ready(o_data_ready), .o_result(o_result), .o_result_valid(o_result_valid)
  );

  tb_itcm u_itcm (
    .clk(clk), .i_addr(o_itcm_addr), .o_data(itcm_data),
    .i_we(wr_en), .i_waddr(wr_addr), .i_wdata(wr_data)
  );

  always #4 clk = ~clk;

  always @(negedge clk) begin
    if (rst_n && o_result_valid) pulse_cnt++;
  end

  // result valid is a single-cycle pulse
  assert property (@(posedge clk) disable iff (!rst_n) o_result_valid |=> !o_result_valid)
    else begin
      other_errs++;
      $display("error: o_result_valid stayed high for more than one cycle");
    end

  initial begin
    #(WATCHDOG_CYC * 8);
    $display("error: simulation timed out, the DUT stopped responding");
    $display("Checks failed");
    $finish;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32,22,2,1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
  endtask

  task automatic value_fail(input string msg);
    val_errs++;
    $display("[FAIL] %0t ns: %s", $time, msg);
  endtask

  task automatic other_fail(input string msg);
    other_errs++;
    $display("error: %s", msg);
  endtask

  // score every class from the packed weight layout and let the lowest index win a tie
  function automatic accel_pkg::class_idx_t ref_class(input feat_vec_t f);
    accel_pkg::weight_word_t word;
    accel_pkg::weight_t      wb;
    int                      s;
    int                      best_s;
    accel_pkg::class_idx_t   best;
    best_s = 0;
    best   = '0;
    for (int c = 0; c < accel_pkg::NUM_CLASS; c++) begin
      s = 0;
      for (int k = 0; k < FEAT_NUM; k++) begin
        word = w_mem[(c % accel_pkg::NUM_BANK) * FEAT_NUM + k];
        wb   = (c < accel_pkg::NUM_BANK) ? word[7:0] : word[15:8];
        s += int'(f[k]) * int'(wb);
      end
      if (c == 0 || s > best_s) begin
        best_s = s;
        best   = accel_pkg::class_idx_t'(c);
      end
    end
    return best;
  endfunction

  task automatic rand_feat(output feat_vec_t f);
    logic [31:0] r;
    for (int k = 0; k < FEAT_NUM; k++) begin
      take_bits(8, r);
      f[k] = r[7:0];
    end
  endtask

  // new random weights; with tie set, row 0 gives classes 3 and 5 the same top weight
  task automatic fill_itcm(input bit tie);
    logic [31:0] r;
    for (int k = 0; k < NUM_WORDS; k++) begin
      take_bits(16, r);
      w_mem[k] = r[15:0];
      if (tie && (k % FEAT_NUM == 0)) begin
        if (w_mem[k][7:0] == 8'h7f) w_mem[k][7:0] = 8'h7e;
        if (w_mem[k][15:8] == 8'h7f) w_mem[k][15:8] = 8'h7e;
      end
    end
    if (tie) begin
      w_mem[3 * FEAT_NUM][7:0]  = 8'h7f; // class 3
      w_mem[1 * FEAT_NUM][15:8] = 8'h7f; // class 5
    end
    for (int k = 0; k < NUM_WORDS; k++) begin
      @(posedge clk);
      wr_en   <= 1'b1;
      wr_addr <= accel_pkg::itcm_addr_t'(k);
      wr_data <= w_mem[k];
    end
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  task automatic load_weights(input bit poke_start);
    int n;
    @(posedge clk);
    i_start <= 1'b1;
    @(posedge clk); // accepting edge
    i_start <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n <= NUM_WORDS) begin
        assert (o_itcm_addr == accel_pkg::itcm_addr_t'(n - 1))
          else value_fail($sformatf("itcm addr %0d, expected %0d", o_itcm_addr, n - 1));
      end
      if (o_data_ready) break;
      @(posedge clk);
      i_start <= poke_start && (n == NUM_WORDS); // seen in the last busy cycle and ignored
    end while (n < NUM_WORDS + 40);
    if (!o_data_ready) begin
      other_fail("o_data_ready never rose after a start");
    end else begin
      assert (n == NUM_WORDS + 2)
        else value_fail($sformatf("ready in cycle t+%0d, expected t+%0d", n, NUM_WORDS + 2));
    end
    @(posedge clk);
    i_start <= 1'b0;
  endtask

  task automatic classify(input feat_vec_t f, input bit poke_start, input bit poke_feat);
    accel_pkg::class_idx_t exp;
    int                    n;
    exp = ref_class(f);
    @(posedge clk);
    i_feat       <= f;
    i_feat_valid <= 1'b1;
    @(posedge clk); // accepting edge
    i_feat_valid <= 1'b0;
    exp_pulses++;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      assert (o_data_ready) else value_fail("o_data_ready fell during a classification");
      if (o_result_valid) break;
      @(posedge clk);
      i_start      <= poke_start && (n == 5);
      i_feat_valid <= poke_feat && (n == 7); // dropped while the engine is busy
    end while (n < 40);
    if (!o_result_valid) begin
      other_fail("no result pulse after an accepted feature beat");
    end else begin
      last_result = o_result;
      assert (n == FEAT_NUM + 2)
        else value_fail($sformatf("result in cycle t+%0d, expected t+%0d", n, FEAT_NUM + 2));
      assert (o_result == exp)
        else value_fail($sformatf("result %0d, expected class %0d", o_result, exp));
    end
    @(posedge clk);
    i_start      <= 1'b0;
    i_feat_valid <= 1'b0;
    @(posedge clk);
  endtask

  initial begin
    feat_vec_t f;
    clk          = 1'b0;
    rst_n        = 1'b0;
    i_start      = 1'b0;
    i_feat       = '0;
    i_feat_valid = 1'b0;
    wr_en        = 1'b0;
    wr_addr      = '0;
    wr_data      = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (!o_data_ready && !o_result_valid) else value_fail("outputs not idle after reset");

    // beats before any load are dropped
    repeat (3) begin
      @(posedge clk);
      i_feat_valid <= 1'b1;
      @(posedge clk);
      i_feat_valid <= 1'b0;
      repeat (20) @(posedge clk);
    end
    assert (pulse_cnt == 0) else value_fail("result pulse before weights were loaded");

    fill_itcm(1'b1);
    load_weights(1'b1);

    f    = '0;
    f[0] = 8'sd1;
    classify(f, 1'b0, 1'b0);
    assert (last_result == 3) else value_fail("tie between classes 3 and 5 not won by 3");
    classify('0, 1'b0, 1'b0);
    assert (last_result == 0) else value_fail("all-zero vector did not give class 0");

    for (int i = 0; i < 16; i++) begin
      rand_feat(f);
      classify(f, (i == 5), (i == 3));
    end

    // idle start reloads fresh weights
    fill_itcm(1'b0);
    load_weights(1'b0);
    for (int i = 0; i < 8; i++) begin
      rand_feat(f);
      classify(f, 1'b0, (i == 2));
    end

    repeat (10) @(posedge clk);
    assert (pulse_cnt == exp_pulses)
      else value_fail($sformatf("%0d result pulses, expected %0d", pulse_cnt, exp_pulses));

    $display("summary: %0d value errors, %0d other errors", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- tb_itcm.sv
`timescale 1ns/1ps

module tb_itcm #(
  parameter int unsigned DEPTH = 64
) (
  input  logic                    clk,
  input  accel_pkg::itcm_addr_t   i_addr,
  output accel_pkg::weight_word_t o_data,
  input  logic                    i_we,    // testbench side load port
  input  accel_pkg::itcm_addr_t   i_waddr,
  input  accel_pkg::weight_word_t i_wdata
);

  accel_pkg::weight_word_t mem [DEPTH];

  // address-dependent fill until the testbench writes real weights
  initial begin
    for (int a = 0; a < DEPTH; a++) begin
      mem[a] = accel_pkg::weight_word_t'((a * 16'h9e37) ^ (a << 3));
    end
  end

  always @(posedge clk) begin
    if (i_we && (i_waddr < DEPTH)) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // data one cycle after the address
  always_ff @(posedge clk) begin
    if (i_addr < DEPTH) begin
      o_data <= mem[i_addr];
    end else begin
      o_data <= '0;
    end
  end

endmodule

//--- nice_accel_top.sv
`timescale 1ns/1ps

module nice_accel_top #(
  parameter int unsigned FEAT_NUM = 12 // at most 16
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            i_start,
  input  accel_pkg::feat_t [FEAT_NUM-1:0] i_feat,
  input  logic                            i_feat_valid,
  input  accel_pkg::weight_word_t         i_itcm_data,
  output accel_pkg::itcm_addr_t           o_itcm_addr,
  output logic                            o_data_ready,
  output accel_pkg::class_idx_t           o_result,
  output logic                            o_result_valid
);

  logic                                              dma_go;
  logic                                              load_busy;
  logic                                              load_done;
  logic                                              fc_go;
  logic                                              fc_busy;
  accel_pkg::bank_wr_t                               bank_wr;
  accel_pkg::bank_row_t                              rd_row;
  accel_pkg::weight_word_t [accel_pkg::NUM_BANK-1:0] rd_words;

  accel_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (i_start),
    .i_feat_valid(i_feat_valid),
    .i_load_busy (load_busy),
    .i_load_done (load_done),
    .i_fc_busy   (fc_busy),
    .o_dma_go    (dma_go),
    .o_fc_go     (fc_go),
    .o_data_ready(o_data_ready)
  );

  weight_dma #(
    .FEAT_NUM(FEAT_NUM)
  ) u_dma (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_go       (dma_go),
    .i_itcm_data(i_itcm_data),
    .o_itcm_addr(o_itcm_addr),
    .o_wr       (bank_wr),
    .o_busy     (load_busy),
    .o_done     (load_done)
  );

  weight_bank #(
    .FEAT_NUM(FEAT_NUM)
  ) u_bank (
    .clk       (clk),
    .i_wr      (bank_wr),
    .i_load    (load_busy),
    .i_rd_row  (rd_row),
    .o_rd_words(rd_words)
  );

  fc_classifier #(
    .FEAT_NUM(FEAT_NUM)
  ) u_fc (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_go          (fc_go),
    .i_feat        (i_feat),
    .i_rd_words    (rd_words),
    .o_rd_row      (rd_row),
    .o_busy        (fc_busy),
    .o_result      (o_result),
    .o_result_valid(o_result_valid)
  );

endmodule

//--- fc_classifier.sv
`timescale 1ns/1ps

module fc_classifier #(
  parameter int unsigned FEAT_NUM = 12
) (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              i_go,
  input  accel_pkg::feat_t [FEAT_NUM-1:0]                   i_feat,
  input  accel_pkg::weight_word_t [accel_pkg::NUM_BANK-1:0] i_rd_words,
  output accel_pkg::bank_row_t                              o_rd_row,
  output logic                                              o_busy,
  output accel_pkg::class_idx_t                             o_result,
  output logic                                              o_result_valid
);

  localparam int unsigned FEAT_W = $bits(accel_pkg::feat_t);
  localparam int unsigned STEP_W = $clog2(FEAT_NUM + 2);

  typedef logic [STEP_W-1:0] step_t;

  localparam step_t LAST_ACC = step_t'(FEAT_NUM);     // last product arrives
  localparam step_t END_STEP = step_t'(FEAT_NUM + 1); // result cycle

  logic                            busy_q;
  step_t                           step_q;
  accel_pkg::feat_t [FEAT_NUM-1:0] feat_q;  // shifted down one feature per row
  accel_pkg::acc_t                 acc_q    [accel_pkg::NUM_CLASS];
  accel_pkg::acc_t                 sum_next [accel_pkg::NUM_CLASS];
  logic                            acc_en;
  accel_pkg::class_idx_t           best_idx;
  accel_pkg::class_idx_t           result_q;
  logic                            result_valid_q;

  // rows read in steps 0..FEAT_NUM-1 and their data seen in steps 1..FEAT_NUM
  assign acc_en   = busy_q && (step_q != '0) && (step_q <= LAST_ACC);
  assign o_rd_row = (step_q < LAST_ACC) ? accel_pkg::bank_row_t'(step_q) : '0;

  // one MAC lane per class
  always_comb begin : p_mac
    accel_pkg::weight_word_t word;
    accel_pkg::weight_t      w;
    logic signed [15:0]      prod;
    for (int c = 0; c < accel_pkg::NUM_CLASS; c++) begin
      word = i_rd_words[c % accel_pkg::NUM_BANK];
      // classes 0..3 in the low byte, 4..7 in the high byte
      w    = (c < accel_pkg::NUM_BANK) ? word[7:0] : word[15:8];
      prod = feat_q[0] * w;
      sum_next[c] = acc_q[c] + accel_pkg::acc_t'(prod);
    end
  end

  // strict compare keeps the lowest index on a tie
  always_comb begin : p_argmax
    accel_pkg::acc_t best_val;
    best_val = sum_next[0];
    best_idx = '0;
    for (int c = 1; c < accel_pkg::NUM_CLASS; c++) begin
      if (sum_next[c] > best_val) begin
        best_val = sum_next[c];
        best_idx = accel_pkg::class_idx_t'(c);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q         <= 1'b0;
      step_q         <= '0;
      result_valid_q <= 1'b0;
    end else begin
      result_valid_q <= 1'b0;
      if (i_go) begin
        busy_q <= 1'b1;
        step_q <= '0;
      end else if (busy_q) begin
        step_q <= step_q + 1'b1;
        if (step_q == LAST_ACC) begin
          result_valid_q <= 1'b1; // final sums go straight to the argmax
        end
        if (step_q == END_STEP) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  // datapath cleared by i_go
  always_ff @(posedge clk) begin
    if (i_go) begin
      feat_q <= i_feat;
      for (int c = 0; c < accel_pkg::NUM_CLASS; c++) begin
        acc_q[c] <= '0;
      end
    end else if (acc_en) begin
      feat_q <= feat_q >> FEAT_W; // next feature into slot 0
      for (int c = 0; c < accel_pkg::NUM_CLASS; c++) begin
        acc_q[c] <= sum_next[c];
      end
    end
    if (acc_en && (step_q == LAST_ACC)) begin
      result_q <= best_idx;
    end
  end

  assign o_busy         = busy_q;
  assign o_result       = result_q;
  assign o_result_valid = result_valid_q;

endmodule

//--- weight_bank.sv
`timescale 1ns/1ps

module weight_bank #(
  parameter int unsigned FEAT_NUM = 12
) (
  input  logic                                          clk,
  input  accel_pkg::bank_wr_t                           i_wr,
  input  logic                                          i_load,
  input  accel_pkg::bank_row_t                          i_rd_row,
  output accel_pkg::weight_word_t [accel_pkg::NUM_BANK-1:0] o_rd_words
);

  logic [accel_pkg::NUM_BANK-1:0] bank_we;
  accel_pkg::bank_row_t           mem_addr;

  // one-hot write enable from the bank field
  always_comb begin
    for (int b = 0; b < accel_pkg::NUM_BANK; b++) begin
      bank_we[b] = i_wr.we && (i_wr.bank == accel_pkg::bank_idx_t'(b));
    end
  end

  // DMA owns the address while loading, the classifier otherwise
  assign mem_addr = i_load ? i_wr.row : i_rd_row;

  for (genvar b = 0; b < accel_pkg::NUM_BANK; b++) begin : g_bank
    weight_sram #(
      .FEAT_NUM(FEAT_NUM)
    ) u_sram (
      .clk   (clk),
      .i_we  (bank_we[b]),
      .i_addr(mem_addr),
      .i_din (i_wr.data),
      .o_dout(o_rd_words[b])
    );
  end

endmodule

//--- weight_sram.sv
`timescale 1ns/1ps

module weight_sram #(
  parameter int unsigned FEAT_NUM = 12
) (
  input  logic                    clk,
  input  logic                    i_we,
  input  accel_pkg::bank_row_t    i_addr,
  input  accel_pkg::weight_word_t i_din,
  output accel_pkg::weight_word_t o_dout
);

  accel_pkg::weight_word_t mem [FEAT_NUM]; // one row per feature

  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_addr] <= i_din;
    end
  end

  // registered read returns old data on a same-row write
  always_ff @(posedge clk) begin
    o_dout <= mem[i_addr];
  end

endmodule

//--- weight_dma.sv
`timescale 1ns/1ps

module weight_dma #(
  parameter int unsigned FEAT_NUM = 12
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    i_go,
  input  accel_pkg::weight_word_t i_itcm_data,
  output accel_pkg::itcm_addr_t   o_itcm_addr,
  output accel_pkg::bank_wr_t     o_wr,
  output logic                    o_busy,
  output logic                    o_done
);

  localparam int unsigned NUM_WORDS = accel_pkg::NUM_BANK * FEAT_NUM;
  localparam accel_pkg::itcm_addr_t LAST_ADDR = accel_pkg::itcm_addr_t'(NUM_WORDS - 1);

  typedef enum logic [1:0] {
    IDLE,
    READ,
    DRAIN
  } state_t;

  state_t                state_q;
  accel_pkg::itcm_addr_t addr_q;   // address presented to the ITCM
  accel_pkg::itcm_addr_t addr_d;   // address of the word now on i_itcm_data
  logic                  rd_vld_q; // i_itcm_data holds a requested word

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= IDLE;
      addr_q   <= '0;
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= (state_q == READ);
      case (state_q)
        IDLE: begin
          if (i_go) begin
            state_q <= READ;
            addr_q  <= '0;
          end
        end
        READ: begin
          if (addr_q == LAST_ADDR) begin
            state_q <= DRAIN; // last word still in flight
          end else begin
            addr_q <= addr_q + 1'b1;
          end
        end
        DRAIN: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // follows the one-cycle ITCM read latency
  always_ff @(posedge clk) begin
    addr_d <= addr_q;
  end

  assign o_itcm_addr = addr_q;

  // word k lands in bank k / FEAT_NUM at row k mod FEAT_NUM
  assign o_wr.we   = rd_vld_q;
  assign o_wr.bank = accel_pkg::bank_idx_t'(addr_d / FEAT_NUM);
  assign o_wr.row  = accel_pkg::bank_row_t'(addr_d % FEAT_NUM);
  assign o_wr.data = i_itcm_data;

  assign o_busy = (state_q != IDLE);
  assign o_done = (state_q == DRAIN); // same cycle as the last bank write

endmodule

//--- accel_ctrl.sv
`timescale 1ns/1ps

module accel_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic i_start,
  input  logic i_feat_valid,
  input  logic i_load_busy,
  input  logic i_load_done,
  input  logic i_fc_busy,
  output logic o_dma_go,
  output logic o_fc_go,
  output logic o_data_ready
);

  logic start_ok;
  logic feat_ok;

  // start only when neither engine is running
  assign start_ok = i_start && !i_load_busy && !i_fc_busy;

  // a start in the same cycle wins since the banks are about to be rewritten
  assign feat_ok = i_feat_valid && o_data_ready && !i_fc_busy && !start_ok;

  assign o_dma_go = start_ok; // one-cycle pulse
  assign o_fc_go  = feat_ok;  // samples i_feat in the classifier

  // ready level cleared by an accepted start and set when the load completes
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_data_ready <= 1'b0;
    end else if (start_ok) begin
      o_data_ready <= 1'b0;
    end else if (i_load_done) begin
      o_data_ready <= 1'b1; // stays high until the next start
    end
  end

endmodule

//--- accel_pkg.sv
package accel_pkg;

  localparam int unsigned NUM_BANK  = 4; // weight banks
  localparam int unsigned NUM_CLASS = 8; // two classes per bank word

  // one feature and one weight
  typedef logic signed [7:0] feat_t;
  typedef logic signed [7:0] weight_t;

  // class b+4 in [15:8], class b in [7:0]
  typedef logic [15:0] weight_word_t;

  typedef logic [15:0] itcm_addr_t; // instruction memory word address
  typedef logic [3:0]  bank_row_t;  // row inside a bank, one per feature
  typedef logic [1:0]  bank_idx_t;  // bank number
  typedef logic [2:0]  class_idx_t; // class number

  // wide enough for 16 products of two 8-bit values
  typedef logic signed [19:0] acc_t;

  // one write into the weight banks, issued by the DMA
  typedef struct packed {
    logic         we;
    bank_idx_t    bank;
    bank_row_t    row;
    weight_word_t data;
  } bank_wr_t;

endpackage
